// File: pext_alu.f
+incdir+src
src/pext_alu_pkg.sv
src/pext_op_decode.sv
src/pext_lane_adder.sv
src/pext_lane_compare.sv
src/pext_bit_count.sv
src/pext_alu.sv
tb/pext_alu_assertions.sv
tb/pext_alu_tb.sv

// File: Bender.yml
package:
  name: pext_alu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/pext_alu_pkg.sv
      - src/pext_op_decode.sv
      - src/pext_lane_adder.sv
      - src/pext_lane_compare.sv
      - src/pext_bit_count.sv
      - src/pext_alu.sv
  - target: simulation
    files:
      - tb/pext_alu_assertions.sv
      - tb/pext_alu_tb.sv

// File: tb/pext_alu_tb.sv
/*
 * Testbench for the packed-SIMD ALU: clock, reset, four-phase stimulus,
 * reference model, compare task and final pass or fail report
 */
`timescale 1ns/1ns

module pext_alu_tb;
  import pext_pkg::*;

  localparam int TIMEOUT = 20;
  localparam int N_DIR   = 10;
  localparam int N_RAND  = 6;

  logic       clk;
  logic       rst;
  logic       req;
  pext_req_t  req_data;
  logic       ack;
  pext_word_t result;
  logic       set_ov;

  // Edge operands, equal/greater/less lanes and single-bit patterns
  pext_word_t dir_a [N_DIR] = '{32'h7f7f7f7f, 32'h80808080, 32'hffffffff, 32'h00000000,
                                32'hffffffff, 32'h00010000, 32'h10807f05, 32'h12348000,
                                32'h7fff0001, 32'h01020408};
  pext_word_t dir_b [N_DIR] = '{32'h01010101, 32'h01010101, 32'h01010101, 32'h00000000,
                                32'hffffffff, 32'h80000000, 32'h107f8006, 32'h12347fff,
                                32'h80000001, 32'h0000ffff};

  pext_alu u_dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .req_data_i (req_data),
    .ack_o      (ack),
    .result_o   (result),
    .set_ov_o   (set_ov)
  );

  bind pext_alu pext_alu_assertions u_assertions (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .result_i (result_o),
    .set_ov_i (set_ov_o),
    .op_i     (req_q.op),
    .state_i  (state_q)
  );

  always #10 clk = ~clk;

  function automatic void stop_on_error(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endfunction

  // Stop at the first failed handshake or flag assertion
  always @(posedge clk) begin
    if (u_dut.u_assertions.fail_count != 0) begin
      stop_on_error("a handshake or flag assertion failed");
    end
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_on_error($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  // One lane of a word, sign or zero extended
  function automatic longint lane_value(input pext_word_t word, input int lsb, input int w,
      input bit sgn);
    longint v;
    v = 0;
    for (int i = 0; i < w; i++) begin
      v[i] = word[lsb+i];
    end
    if (sgn && word[lsb+w-1]) begin
      v = v - (longint'(1) << w);
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model, returns {flag, result}
  //////////////////////////////////////////////////////////////////////
  function automatic logic [32:0] expected_result(input pext_op_e op, input pext_word_t a,
      input pext_word_t b);
    string      s;
    string      base;
    int         n;
    int         w;
    bit         sgn;
    bit         sat;
    bit         flag;
    bit         run;
    bit         sign;
    longint     la;
    longint     lb;
    longint     lo;
    longint     hi;
    longint     r;
    pext_word_t y;
    s = op.name();
    n = s.len();
    // Lane width from the name suffix: 8, 16, 32 or W
    w = (s[n-1] == "8") ? 8 : (s[n-1] == "6") ? 16 : 32;
    base = s.substr(0, n - ((s[n-1] == "8" || s[n-1] == "W") ? 2 : 3));
    sgn  = (base[0] != "U");
    flag = 1'b0;
    y    = '0;
    for (int lsb = 0; lsb < 32; lsb += w) begin
      la  = lane_value(a, lsb, w, sgn);
      lb  = lane_value(b, lsb, w, sgn);
      lo  = sgn ? -(longint'(1) << (w-1)) : 0;
      hi  = sgn ? (longint'(1) << (w-1)) - 1 : (longint'(1) << w) - 1;
      sat = 1'b0;
      r   = 0;
      case (base)
        "ADD":            r = la + lb;
        "SUB":            r = la - lb;
        "RADD", "URADD":  r = (la + lb) >>> 1;
        "RSUB", "URSUB":  r = (la - lb) >>> 1;
        "KADD", "UKADD": begin
          r   = la + lb;
          sat = 1'b1;
        end
        "KSUB", "UKSUB": begin
          r   = la - lb;
          sat = 1'b1;
        end
        "CMPEQ":            r = (la == lb) ? -1 : 0;
        "SCMPLT", "UCMPLT": r = (la < lb) ? -1 : 0;
        "SCMPLE", "UCMPLE": r = (la <= lb) ? -1 : 0;
        "SMIN", "UMIN":     r = (la <= lb) ? la : lb;
        "SMAX", "UMAX":     r = (la > lb) ? la : lb;
        "CLZ", "CLRS": begin
          // CLRS scans below the sign bit for copies of it
          sign = (base == "CLRS") & a[lsb+w-1];
          run  = 1'b1;
          for (int i = (base == "CLRS") ? w-2 : w-1; i >= 0; i--) begin
            run = run & (a[lsb+i] == sign);
            r += run;
          end
        end
        default: stop_on_error({"no reference rule for opcode ", s});
      endcase
      if (sat && r > hi) begin
        r    = hi;
        flag = 1'b1;
      end else if (sat && r < lo) begin
        r    = lo;
        flag = 1'b1;
      end
      for (int i = 0; i < w; i++) begin
        y[lsb+i] = r[i];
      end
    end
    return {flag, y};
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // Full four-phase transaction with output checks
  task automatic run_op(input string name, input pext_op_e op, input pext_word_t a,
      input pext_word_t b);
    logic [32:0] exp;
    int          cycles;
    int          hold;
    exp  = expected_result(op, a, b);
    hold = $urandom_range(5, 0);
    tick();
    req_data = '{op: op, a: a, b: b};
    req      = 1'b1;
    cycles   = 0;
    do begin
      tick();
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error($sformatf("%s: no ack within %0d cycles", name, TIMEOUT));
      end
    end while (!ack);
    check_value({name, " ack delay"}, 2, cycles);
    check_value({name, " result"}, exp[31:0], result);
    check_value({name, " set_ov"}, exp[32], set_ov);
    // Slow requester, ack and result must hold
    repeat (hold) begin
      tick();
      check_value({name, " ack hold"}, 1, ack);
      check_value({name, " result hold"}, exp[31:0], result);
    end
    req    = 1'b0;
    cycles = 0;
    do begin
      tick();
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_on_error($sformatf("%s: ack still high %0d cycles after req fell", name, TIMEOUT));
      end
    end while (ack);
    check_value({name, " ack release"}, 1, cycles);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    pext_op_e op;
    clk      = 1'b0;
    rst      = 1'b1;
    req      = 1'b0;
    req_data = '0;
    void'($urandom(32'h8ab));
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    check_value("reset ack", 0, ack);
    check_value("reset set_ov", 0, set_ov);
    check_value("reset result", 0, result);
    check_value("reset state", IDLE, u_dut.state_q);

    // Every opcode over the directed pairs, then random operands
    op = op.first();
    for (int k = 0; k < op.num(); k++) begin
      for (int i = 0; i < N_DIR; i++) begin
        run_op($sformatf("%s dir%0d", op.name(), i), op, dir_a[i], dir_b[i]);
      end
      for (int i = 0; i < N_RAND; i++) begin
        run_op($sformatf("%s rnd%0d", op.name(), i), op, $urandom(), $urandom());
      end
      op = op.next();
    end

    tick();
    if (u_dut.u_assertions.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("%0d assertion failures", u_dut.u_assertions.fail_count);
      $display("=== FAIL ===");
      $fatal(1, "assertion failures during run");
    end
  end

endmodule

// File: tb/pext_alu_assertions.sv
/*
 * Handshake and overflow flag assertions, bound into the ALU top
 */
`timescale 1ns/1ns

module pext_alu_assertions (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 req_i,
  input logic                 ack_i,
  input pext_pkg::pext_word_t result_i,
  input logic                 set_ov_i,
  input pext_pkg::pext_op_e   op_i,
  input pext_pkg::state_e     state_i
);
  import pext_pkg::*;

  int fail_count = 0;

  // Ack only answers a request seen on the edge that raised it
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i))
  else begin
    $error("ack rose while req was low");
    fail_count++;
  end

  ack_release: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i && !req_i |=> !ack_i)
  else begin
    $error("ack did not fall one cycle after req fell");
    fail_count++;
  end

  // Result and flag frozen for the whole ack phase
  hold_outputs: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i ##1 ack_i |-> $stable(result_i) && $stable(set_ov_i))
  else begin
    $error("outputs changed while ack was high");
    fail_count++;
  end

  ov_only_sat: assert property (@(posedge clk_i) disable iff (rst_i)
    state_i == DONE && !(op_i inside {KADD8, KADD16, KADDW, KSUB8, KSUB16, KSUBW,
      UKADD8, UKADD16, UKADDW, UKSUB8, UKSUB16, UKSUBW}) |-> !set_ov_i)
  else begin
    $error("overflow flag set by a non-saturating opcode");
    fail_count++;
  end

endmodule

// File: src/pext_alu.sv
/*
 * Packed-SIMD ALU top: four-phase req/ack handshake, request register,
 * datapath result select and registered outputs
 */
`timescale 1ns/1ns

module pext_alu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  input  pext_pkg::pext_req_t  req_data_i,
  output logic                 ack_o,
  output pext_pkg::pext_word_t result_o,
  output logic                 set_ov_o
);
  import pext_pkg::*;

  state_e     state_q;
  pext_req_t  req_q;
  pext_ctrl_t ctrl;
  pext_word_t wrap;
  pext_word_t sum;
  pext_word_t cmp_mask;
  pext_word_t minmax;
  pext_word_t count;
  pext_word_t result_d;
  lane_mask_t ovf;
  logic       set_ov_d;

  // Request latched on acceptance, held for the whole transaction
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      req_q <= req_data_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////
  pext_op_decode u_decode (
    .op_i   (req_q.op),
    .ctrl_o (ctrl)
  );

  pext_lane_adder u_adder (
    .a_i    (req_q.a),
    .b_i    (req_q.b),
    .ctrl_i (ctrl),
    .wrap_o (wrap),
    .sum_o  (sum),
    .ovf_o  (ovf)
  );

  pext_lane_compare u_compare (
    .a_i      (req_q.a),
    .b_i      (req_q.b),
    .diff_i   (wrap),
    .ctrl_i   (ctrl),
    .mask_o   (cmp_mask),
    .minmax_o (minmax)
  );

  pext_bit_count u_bit_count (
    .a_i     (req_q.a),
    .ctrl_i  (ctrl),
    .count_o (count)
  );

  always_comb begin
    case (ctrl.result_sel)
      ADDER:   result_d = sum;
      COMPARE: result_d = cmp_mask;
      MINMAX:  result_d = minmax;
      default: result_d = count;
    endcase
  end

  // Flag only for the saturating opcodes
  assign set_ov_d = (ctrl.add_mode == SATURATE) & (|ovf);

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= IDLE;
      ack_o    <= 1'b0;
      result_o <= '0;
      set_ov_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_i) begin
            state_q <= BUSY;
          end
        end
        BUSY: begin
          result_o <= result_d;
          set_ov_o <= set_ov_d;
          ack_o    <= 1'b1;
          state_q  <= DONE;
        end
        DONE: begin
          // Hold outputs until the requester drops req
          if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: src/pext_bit_count.sv
/*
 * Leading-zero and leading-redundant-sign counter: per-lane prefix
 * chain followed by a layered adder tree
 */
`timescale 1ns/1ns
`include "pext_alu_defs.svh"

module pext_bit_count (
  input  pext_pkg::pext_word_t a_i,
  input  pext_pkg::pext_ctrl_t ctrl_i,
  output pext_pkg::pext_word_t count_o
);
  import pext_pkg::*;

  localparam int BW = `PEXT_BYTE;

  lane_mask_t          top;
  lane_mask_t          sign_b;
  lane_mask_t          neg;
  logic [`PEXT_XLEN:0] run;
  pext_word_t          marked;
  logic                lane_msb;
  logic                x_bit;
  logic [1:0]          l1 [16];
  logic [2:0]          l2 [8];
  logic [3:0]          l3 [4];
  logic [4:0]          l4 [2];
  logic [5:0]          l5;

  assign top = lane_top(ctrl_i.width);

  // CLRS counts zeros of the lane after flipping negative lanes
  always_comb begin
    for (int k = 0; k < `PEXT_LANES; k++) begin
      sign_b[k] = a_i[BW*k+BW-1];
    end
  end

  assign neg = ctrl_i.clrs ? spread_top(sign_b, ctrl_i.width) : '0;

  //////////////////////////////////////////////////////////////////////
  // Prefix chain
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    run[`PEXT_XLEN] = 1'b1;
    for (int i = `PEXT_XLEN-1; i >= 0; i--) begin
      lane_msb  = ((i % BW) == BW-1) && top[i/BW];
      x_bit     = a_i[i] ^ neg[i/BW];
      run[i]    = ~x_bit & (lane_msb | run[i+1]);
      // Sign bit is not part of a CLRS count
      marked[i] = run[i] & ~(ctrl_i.clrs & lane_msb);
    end
  end

  // Adder tree, tapped per lane width
  for (genvar i = 0; i < 16; i++) begin : g_l1
    assign l1[i] = {1'b0, marked[2*i]} + {1'b0, marked[2*i+1]};
  end
  for (genvar i = 0; i < 8; i++) begin : g_l2
    assign l2[i] = {1'b0, l1[2*i]} + {1'b0, l1[2*i+1]};
  end
  for (genvar i = 0; i < 4; i++) begin : g_l3
    assign l3[i] = {1'b0, l2[2*i]} + {1'b0, l2[2*i+1]};
  end
  for (genvar i = 0; i < 2; i++) begin : g_l4
    assign l4[i] = {1'b0, l3[2*i]} + {1'b0, l3[2*i+1]};
  end
  assign l5 = {1'b0, l4[0]} + {1'b0, l4[1]};

  always_comb begin
    case (ctrl_i.width)
      LANE8:   count_o = {4'h0, l3[3], 4'h0, l3[2], 4'h0, l3[1], 4'h0, l3[0]};
      LANE16:  count_o = {11'h0, l4[1], 11'h0, l4[0]};
      default: count_o = {26'h0, l5};
    endcase
  end

endmodule

// File: src/pext_lane_compare.sv
/*
 * Lane compare: equal and less-than per lane, compare masks and
 * min/max lane selection
 */
`timescale 1ns/1ns
`include "pext_alu_defs.svh"

module pext_lane_compare (
  input  pext_pkg::pext_word_t a_i,
  input  pext_pkg::pext_word_t b_i,
  input  pext_pkg::pext_word_t diff_i,
  input  pext_pkg::pext_ctrl_t ctrl_i,
  output pext_pkg::pext_word_t mask_o,
  output pext_pkg::pext_word_t minmax_o
);
  import pext_pkg::*;

  localparam int BW = `PEXT_BYTE;

  lane_mask_t byte_eq;
  lane_mask_t byte_lt;
  lane_mask_t lane_eq;
  lane_mask_t lane_lt;
  lane_mask_t sel;

  // Byte flags from a - b and the operand MSBs
  always_comb begin
    for (int k = 0; k < `PEXT_LANES; k++) begin
      byte_eq[k] = (diff_i[BW*k +: BW] == '0);
      if (a_i[BW*k+BW-1] == b_i[BW*k+BW-1]) begin
        // same half of the range, so the difference cannot wrap
        byte_lt[k] = diff_i[BW*k+BW-1];
      end else begin
        byte_lt[k] = ctrl_i.is_signed ? a_i[BW*k+BW-1] : b_i[BW*k+BW-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lane merge
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i.width)
      LANE8:   lane_eq = byte_eq;
      LANE16:  lane_eq = {{2{&byte_eq[3:2]}}, {2{&byte_eq[1:0]}}};
      default: lane_eq = {4{&byte_eq}};
    endcase
  end

  // Less-than lives in the lane's top byte
  assign lane_lt = spread_top(byte_lt, ctrl_i.width);

  // Per-lane select, also drives min/max
  always_comb begin
    case (ctrl_i.cmp_kind)
      EQ:      sel = lane_eq;
      LT:      sel = lane_lt;
      MAX:     sel = ~(lane_eq | lane_lt);
      default: sel = lane_eq | lane_lt;
    endcase
  end

  // Widen to bytes
  always_comb begin
    for (int k = 0; k < `PEXT_LANES; k++) begin
      mask_o[BW*k +: BW]   = {BW{sel[k]}};
      minmax_o[BW*k +: BW] = sel[k] ? a_i[BW*k +: BW] : b_i[BW*k +: BW];
    end
  end

endmodule

// File: src/pext_lane_adder.sv
/*
 * Carry-segmented lane adder built from byte adders, with wrapped,
 * halving and saturating sums and per-lane overflow
 */
`timescale 1ns/1ns
`include "pext_alu_defs.svh"

module pext_lane_adder (
  input  pext_pkg::pext_word_t a_i,
  input  pext_pkg::pext_word_t b_i,
  input  pext_pkg::pext_ctrl_t ctrl_i,
  output pext_pkg::pext_word_t wrap_o,
  output pext_pkg::pext_word_t sum_o,
  output pext_pkg::lane_mask_t ovf_o
);
  import pext_pkg::*;

  localparam int BW = `PEXT_BYTE;

  lane_mask_t           top;
  lane_mask_t           start;
  lane_mask_t           ext_a;
  lane_mask_t           ext_b;
  lane_mask_t           cin;
  lane_mask_t           clamp;
  lane_mask_t           neg;
  lane_mask_t           lane_neg;
  logic [`PEXT_LANES:0] carry;
  logic [BW:0]          byte_sum [`PEXT_LANES];
  pext_word_t           b_in;
  pext_word_t           halve;
  pext_word_t           sat;

  // Lane edges for the current width
  assign top   = lane_top(ctrl_i.width);
  assign start = {top[`PEXT_LANES-2:0], 1'b1};

  // Subtract as a + ~b + 1
  assign b_in = ctrl_i.sub ? ~b_i : b_i;

  //////////////////////////////////////////////////////////////////////
  // Byte adders
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    carry = '0;
    for (int k = 0; k < `PEXT_LANES; k++) begin
      // Extension bit only on a lane's top byte, so bit BW is the true MSB
      ext_a[k] = top[k] & ctrl_i.is_signed & a_i[BW*k+BW-1];
      ext_b[k] = top[k] & (ctrl_i.is_signed ? b_in[BW*k+BW-1] : ctrl_i.sub);
      // Carry breaks where a new lane starts
      cin[k]   = start[k] ? ctrl_i.sub : carry[k];
      byte_sum[k] = {ext_a[k], a_i[BW*k +: BW]} + {ext_b[k], b_in[BW*k +: BW]} + cin[k];
      carry[k+1]  = byte_sum[k][BW];
      wrap_o[BW*k +: BW] = byte_sum[k][BW-1:0];
    end
  end

  // Halving keeps the top w bits of the (w+1)-bit result
  always_comb begin
    halve = {1'b0, wrap_o[`PEXT_XLEN-1:1]};
    for (int k = 0; k < `PEXT_LANES; k++) begin
      if (top[k]) begin
        halve[BW*k+BW-1] = byte_sum[k][BW];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Saturation
  //////////////////////////////////////////////////////////////////////
  // Signed lanes overflow when the two top bits differ, unsigned on carry or borrow
  always_comb begin
    for (int k = 0; k < `PEXT_LANES; k++) begin
      neg[k] = byte_sum[k][BW];
      if (ctrl_i.is_signed) begin
        clamp[k] = top[k] & (byte_sum[k][BW] ^ byte_sum[k][BW-1]);
      end else begin
        clamp[k] = top[k] & byte_sum[k][BW];
      end
    end
  end

  assign ovf_o    = spread_top(clamp, ctrl_i.width);
  assign lane_neg = spread_top(neg, ctrl_i.width);

  // Bounds per byte: top byte gets 0x80/0x7f, lower bytes 0x00/0xff
  always_comb begin
    for (int k = 0; k < `PEXT_LANES; k++) begin
      if (!ovf_o[k]) begin
        sat[BW*k +: BW] = wrap_o[BW*k +: BW];
      end else if (!ctrl_i.is_signed) begin
        sat[BW*k +: BW] = {BW{~ctrl_i.sub}};
      end else if (top[k]) begin
        sat[BW*k +: BW] = {lane_neg[k], {(BW-1){~lane_neg[k]}}};
      end else begin
        sat[BW*k +: BW] = {BW{~lane_neg[k]}};
      end
    end
  end

  // Output select
  always_comb begin
    case (ctrl_i.add_mode)
      HALVE:    sum_o = halve;
      SATURATE: sum_o = sat;
      default:  sum_o = wrap_o;
    endcase
  end

endmodule

// File: src/pext_op_decode.sv
/*
 * Opcode decoder: maps each packed-SIMD opcode to datapath control
 */
`timescale 1ns/1ns

module pext_op_decode (
  input  pext_pkg::pext_op_e   op_i,
  output pext_pkg::pext_ctrl_t ctrl_o
);
  import pext_pkg::*;

  // Compare and min/max always run the adder as a subtractor
  always_comb begin
    unique case (op_i)
      //                  width   sgn   sub   mode      kind source   clrs
      ADD8:     ctrl_o = '{LANE8,  1'b0, 1'b0, WRAP,     EQ,  ADDER,   1'b0};
      ADD16:    ctrl_o = '{LANE16, 1'b0, 1'b0, WRAP,     EQ,  ADDER,   1'b0};
      ADDW:     ctrl_o = '{LANE32, 1'b0, 1'b0, WRAP,     EQ,  ADDER,   1'b0};
      SUB8:     ctrl_o = '{LANE8,  1'b0, 1'b1, WRAP,     EQ,  ADDER,   1'b0};
      SUB16:    ctrl_o = '{LANE16, 1'b0, 1'b1, WRAP,     EQ,  ADDER,   1'b0};
      SUBW:     ctrl_o = '{LANE32, 1'b0, 1'b1, WRAP,     EQ,  ADDER,   1'b0};
      // Halving
      RADD8:    ctrl_o = '{LANE8,  1'b1, 1'b0, HALVE,    EQ,  ADDER,   1'b0};
      RADD16:   ctrl_o = '{LANE16, 1'b1, 1'b0, HALVE,    EQ,  ADDER,   1'b0};
      RADDW:    ctrl_o = '{LANE32, 1'b1, 1'b0, HALVE,    EQ,  ADDER,   1'b0};
      RSUB8:    ctrl_o = '{LANE8,  1'b1, 1'b1, HALVE,    EQ,  ADDER,   1'b0};
      RSUB16:   ctrl_o = '{LANE16, 1'b1, 1'b1, HALVE,    EQ,  ADDER,   1'b0};
      RSUBW:    ctrl_o = '{LANE32, 1'b1, 1'b1, HALVE,    EQ,  ADDER,   1'b0};
      URADD8:   ctrl_o = '{LANE8,  1'b0, 1'b0, HALVE,    EQ,  ADDER,   1'b0};
      URADD16:  ctrl_o = '{LANE16, 1'b0, 1'b0, HALVE,    EQ,  ADDER,   1'b0};
      URADDW:   ctrl_o = '{LANE32, 1'b0, 1'b0, HALVE,    EQ,  ADDER,   1'b0};
      URSUB8:   ctrl_o = '{LANE8,  1'b0, 1'b1, HALVE,    EQ,  ADDER,   1'b0};
      URSUB16:  ctrl_o = '{LANE16, 1'b0, 1'b1, HALVE,    EQ,  ADDER,   1'b0};
      URSUBW:   ctrl_o = '{LANE32, 1'b0, 1'b1, HALVE,    EQ,  ADDER,   1'b0};
      // Saturating
      KADD8:    ctrl_o = '{LANE8,  1'b1, 1'b0, SATURATE, EQ,  ADDER,   1'b0};
      KADD16:   ctrl_o = '{LANE16, 1'b1, 1'b0, SATURATE, EQ,  ADDER,   1'b0};
      KADDW:    ctrl_o = '{LANE32, 1'b1, 1'b0, SATURATE, EQ,  ADDER,   1'b0};
      KSUB8:    ctrl_o = '{LANE8,  1'b1, 1'b1, SATURATE, EQ,  ADDER,   1'b0};
      KSUB16:   ctrl_o = '{LANE16, 1'b1, 1'b1, SATURATE, EQ,  ADDER,   1'b0};
      KSUBW:    ctrl_o = '{LANE32, 1'b1, 1'b1, SATURATE, EQ,  ADDER,   1'b0};
      UKADD8:   ctrl_o = '{LANE8,  1'b0, 1'b0, SATURATE, EQ,  ADDER,   1'b0};
      UKADD16:  ctrl_o = '{LANE16, 1'b0, 1'b0, SATURATE, EQ,  ADDER,   1'b0};
      UKADDW:   ctrl_o = '{LANE32, 1'b0, 1'b0, SATURATE, EQ,  ADDER,   1'b0};
      UKSUB8:   ctrl_o = '{LANE8,  1'b0, 1'b1, SATURATE, EQ,  ADDER,   1'b0};
      UKSUB16:  ctrl_o = '{LANE16, 1'b0, 1'b1, SATURATE, EQ,  ADDER,   1'b0};
      UKSUBW:   ctrl_o = '{LANE32, 1'b0, 1'b1, SATURATE, EQ,  ADDER,   1'b0};
      // Compares
      CMPEQ8:   ctrl_o = '{LANE8,  1'b0, 1'b1, WRAP,     EQ,  COMPARE, 1'b0};
      CMPEQ16:  ctrl_o = '{LANE16, 1'b0, 1'b1, WRAP,     EQ,  COMPARE, 1'b0};
      SCMPLT8:  ctrl_o = '{LANE8,  1'b1, 1'b1, WRAP,     LT,  COMPARE, 1'b0};
      SCMPLT16: ctrl_o = '{LANE16, 1'b1, 1'b1, WRAP,     LT,  COMPARE, 1'b0};
      SCMPLE8:  ctrl_o = '{LANE8,  1'b1, 1'b1, WRAP,     LE,  COMPARE, 1'b0};
      SCMPLE16: ctrl_o = '{LANE16, 1'b1, 1'b1, WRAP,     LE,  COMPARE, 1'b0};
      UCMPLT8:  ctrl_o = '{LANE8,  1'b0, 1'b1, WRAP,     LT,  COMPARE, 1'b0};
      UCMPLT16: ctrl_o = '{LANE16, 1'b0, 1'b1, WRAP,     LT,  COMPARE, 1'b0};
      UCMPLE8:  ctrl_o = '{LANE8,  1'b0, 1'b1, WRAP,     LE,  COMPARE, 1'b0};
      UCMPLE16: ctrl_o = '{LANE16, 1'b0, 1'b1, WRAP,     LE,  COMPARE, 1'b0};
      // Min and max
      SMIN8:    ctrl_o = '{LANE8,  1'b1, 1'b1, WRAP,     MIN, MINMAX,  1'b0};
      SMIN16:   ctrl_o = '{LANE16, 1'b1, 1'b1, WRAP,     MIN, MINMAX,  1'b0};
      SMAX8:    ctrl_o = '{LANE8,  1'b1, 1'b1, WRAP,     MAX, MINMAX,  1'b0};
      SMAX16:   ctrl_o = '{LANE16, 1'b1, 1'b1, WRAP,     MAX, MINMAX,  1'b0};
      UMIN8:    ctrl_o = '{LANE8,  1'b0, 1'b1, WRAP,     MIN, MINMAX,  1'b0};
      UMIN16:   ctrl_o = '{LANE16, 1'b0, 1'b1, WRAP,     MIN, MINMAX,  1'b0};
      UMAX8:    ctrl_o = '{LANE8,  1'b0, 1'b1, WRAP,     MAX, MINMAX,  1'b0};
      UMAX16:   ctrl_o = '{LANE16, 1'b0, 1'b1, WRAP,     MAX, MINMAX,  1'b0};
      // Bit counts
      CLZ8:     ctrl_o = '{LANE8,  1'b0, 1'b0, WRAP,     EQ,  BITCNT,  1'b0};
      CLZ16:    ctrl_o = '{LANE16, 1'b0, 1'b0, WRAP,     EQ,  BITCNT,  1'b0};
      CLZ32:    ctrl_o = '{LANE32, 1'b0, 1'b0, WRAP,     EQ,  BITCNT,  1'b0};
      CLRS8:    ctrl_o = '{LANE8,  1'b1, 1'b0, WRAP,     EQ,  BITCNT,  1'b1};
      CLRS16:   ctrl_o = '{LANE16, 1'b1, 1'b0, WRAP,     EQ,  BITCNT,  1'b1};
      CLRS32:   ctrl_o = '{LANE32, 1'b1, 1'b0, WRAP,     EQ,  BITCNT,  1'b1};
      default:  ctrl_o = '{LANE32, 1'b0, 1'b0, WRAP,     EQ,  ADDER,   1'b0};
    endcase
  end

endmodule

// File: src/pext_alu_pkg.sv
/*
 * Shared types for the packed-SIMD ALU: data words, opcode and control
 * enums, decoded control and request structs, lane edge helpers
 */
`include "pext_alu_defs.svh"

package pext_pkg;

  typedef logic [`PEXT_XLEN-1:0]  pext_word_t;
  typedef logic [`PEXT_LANES-1:0] lane_mask_t;

  typedef enum logic [`PEXT_OP_W-1:0] {
    // Wrapping
    ADD8, ADD16, ADDW, SUB8, SUB16, SUBW,
    // Halving
    RADD8, RADD16, RADDW, RSUB8, RSUB16, RSUBW,
    URADD8, URADD16, URADDW, URSUB8, URSUB16, URSUBW,
    // Saturating
    KADD8, KADD16, KADDW, KSUB8, KSUB16, KSUBW,
    UKADD8, UKADD16, UKADDW, UKSUB8, UKSUB16, UKSUBW,
    // Lane compares
    CMPEQ8, CMPEQ16, SCMPLT8, SCMPLT16, SCMPLE8, SCMPLE16,
    UCMPLT8, UCMPLT16, UCMPLE8, UCMPLE16,
    // Min and max
    SMIN8, SMIN16, SMAX8, SMAX16, UMIN8, UMIN16, UMAX8, UMAX16,
    // Bit counts
    CLZ8, CLZ16, CLZ32, CLRS8, CLRS16, CLRS32
  } pext_op_e;

  typedef enum logic [1:0] {LANE8, LANE16, LANE32} lane_width_e;
  typedef enum logic [1:0] {ADDER, COMPARE, MINMAX, BITCNT} result_sel_e;
  typedef enum logic [1:0] {WRAP, HALVE, SATURATE} add_mode_e;
  typedef enum logic [2:0] {EQ, LT, LE, MIN, MAX} cmp_kind_e;
  typedef enum logic [1:0] {IDLE, BUSY, DONE} state_e;

  // Decoded datapath control
  typedef struct packed {
    lane_width_e width;
    logic        is_signed;
    logic        sub;
    add_mode_e   add_mode;
    cmp_kind_e   cmp_kind;
    result_sel_e result_sel;
    logic        clrs;
  } pext_ctrl_t;

  typedef struct packed {
    pext_op_e   op;
    pext_word_t a;
    pext_word_t b;
  } pext_req_t;

  // Bytes holding the MSB of a lane
  function automatic lane_mask_t lane_top(lane_width_e width);
    case (width)
      LANE8:   return 4'b1111;
      LANE16:  return 4'b1010;
      default: return 4'b1000;
    endcase
  endfunction

  // Copy the bit of each lane's top byte over all bytes of the lane
  function automatic lane_mask_t spread_top(lane_mask_t bits, lane_width_e width);
    case (width)
      LANE8:   return bits;
      LANE16:  return {{2{bits[3]}}, {2{bits[1]}}};
      default: return {4{bits[3]}};
    endcase
  endfunction

endpackage

// File: src/pext_alu_defs.svh
/*
 * Width macros for the packed-SIMD ALU: word, lane and opcode sizes
 */
`ifndef PEXT_ALU_DEFS_SVH
`define PEXT_ALU_DEFS_SVH

// Data word
`define PEXT_XLEN 32

// Narrowest lane, also the byte adder width
`define PEXT_BYTE 8

// Byte lanes in one word
`define PEXT_LANES 4

// Opcode field
`define PEXT_OP_W 6

`endif
